/* verilog/ifetch_defs.svh */
`ifndef IFETCH_DEFS_SVH
`define IFETCH_DEFS_SVH

// Address and instruction word width
`define IFETCH_ADDR_W 32

// Instruction buffer entries between bus and decode
`define IFETCH_BUF_DEPTH 4

// Bus requests in flight at most, also the tag FIFO depth
`define IFETCH_MAX_OUTST 2

`endif

/* verilog/ifetch_pkg.sv */
`include "ifetch_defs.svh"

package ifetch_pkg;

  // Privilege levels, encoded as in the privileged spec
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } privlvl_t;

  // One granted request waiting for its response
  typedef struct packed {
    logic [`IFETCH_ADDR_W-1:0] addr;
    privlvl_t                  priv;
  } req_tag_t;

  // One fetched instruction on its way to decode
  typedef struct packed {
    logic [`IFETCH_ADDR_W-1:0] addr;
    logic [`IFETCH_ADDR_W-1:0] instr;
    privlvl_t                  priv;
  } fetch_entry_t;

endpackage

/* verilog/ifetch_fifo.sv */
`timescale 1ns/1ps

module ifetch_fifo #(
  parameter type         ENTRY_T = logic [31:0],
  parameter int unsigned DEPTH   = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  ENTRY_T                     push_data_i,
  input  logic                       pop_i,
  output ENTRY_T                     pop_data_o,
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  // Pointer needs at least one bit even for a single entry
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  ENTRY_T           mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  // Guard against overflow and underflow
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign empty_o    = (cnt_q == '0);
  assign full_o     = (cnt_q == FULL_CNT);
  assign count_o    = cnt_q;
  assign pop_data_o = mem_q[rd_ptr_q];

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // Flush wins over a push or pop in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* verilog/ifetch_prefetcher.sv */
`timescale 1ns/1ps
`include "ifetch_defs.svh"

module ifetch_prefetcher (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [`IFETCH_ADDR_W-1:0]              boot_addr_i,
  input  logic                                   halt_i,
  input  logic                                   kill_i,
  input  logic                                   branch_i,
  input  logic [`IFETCH_ADDR_W-1:0]              branch_addr_i,
  input  ifetch_pkg::privlvl_t                   priv_lvl_i,
  input  logic [$clog2(`IFETCH_BUF_DEPTH+1)-1:0] buf_free_i,
  output logic                                   bus_req_o,
  output logic [`IFETCH_ADDR_W-1:0]              bus_addr_o,
  input  logic                                   bus_gnt_i,
  input  logic                                   bus_rvalid_i,
  input  logic [`IFETCH_ADDR_W-1:0]              bus_rdata_i,
  output logic                                   resp_valid_o,
  output ifetch_pkg::fetch_entry_t               resp_entry_o
);

  import ifetch_pkg::*;

  localparam int unsigned AW        = `IFETCH_ADDR_W;
  localparam int unsigned OUT_CNT_W = $clog2(`IFETCH_MAX_OUTST + 1);
  localparam int unsigned BUF_CNT_W = $clog2(`IFETCH_BUF_DEPTH + 1);

  logic                 active_q;
  logic                 boot_q;
  logic [AW-1:0]        pc_q;
  logic [AW-1:0]        fetch_addr;
  logic                 hold_q;
  logic                 hold_d;
  logic [AW-1:0]        hold_addr_q;
  logic                 stale_q;
  logic [OUT_CNT_W-1:0] discard_q;
  logic [OUT_CNT_W-1:0] outst_nxt;
  logic [BUF_CNT_W:0]   need_slots;
  logic                 space_ok;
  logic                 new_req;
  logic                 tag_push;
  logic                 tag_pop;
  logic                 tag_full;
  logic [OUT_CNT_W-1:0] tag_count;
  req_tag_t             tag_in;
  req_tag_t             tag_head;

  //////////////////////////////////////////////////////////////////////
  // Request issue
  //////////////////////////////////////////////////////////////////////

  // Boot address until the first grant or branch
  assign fetch_addr = boot_q ? boot_addr_i : pc_q;

  // Every request in flight plus the new one must find a buffer slot
  always_comb begin
    need_slots                = '0;
    need_slots[OUT_CNT_W-1:0] = tag_count;
    need_slots                = need_slots + 1'b1;
  end

  assign space_ok = ~tag_full & (need_slots <= {1'b0, buf_free_i});

  // New request only when nothing is held and the controller allows it
  assign new_req = active_q & ~hold_q & ~halt_i & ~kill_i & space_ok;

  // A raised request stays up with its address until granted
  assign bus_req_o  = hold_q | new_req;
  assign bus_addr_o = hold_q ? hold_addr_q : fetch_addr;
  assign hold_d     = bus_req_o & ~bus_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      hold_q   <= 1'b0;
      stale_q  <= 1'b0;
    end else begin
      active_q <= 1'b1;
      hold_q   <= hold_d;
      // Held request from before a kill belongs to the dead stream
      stale_q  <= (stale_q | kill_i) & hold_d;
    end
  end

  always_ff @(posedge clk) begin
    if (hold_d) begin
      hold_addr_q <= bus_addr_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fetch PC
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_q <= 1'b1;
      pc_q   <= '0;
    end else if (kill_i && branch_i) begin
      boot_q <= 1'b0;
      pc_q   <= branch_addr_i;
    end else if (tag_push && !stale_q && !kill_i) begin
      // Grants of killed requests leave the PC alone
      boot_q <= 1'b0;
      pc_q   <= bus_addr_o + AW'(4);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outstanding tags and discard
  //////////////////////////////////////////////////////////////////////

  assign tag_push = bus_req_o & bus_gnt_i;
  assign tag_pop  = bus_rvalid_i;

  // Level is sampled at grant, legal since it only moves with a kill
  assign tag_in.addr = bus_addr_o;
  assign tag_in.priv = priv_lvl_i;

  ifetch_fifo #(
    .ENTRY_T (req_tag_t),
    .DEPTH   (`IFETCH_MAX_OUTST)
  ) u_tag_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (1'b0),
    .push_i      (tag_push),
    .push_data_i (tag_in),
    .pop_i       (tag_pop),
    .pop_data_o  (tag_head),
    .empty_o     (),
    .full_o      (tag_full),
    .count_o     (tag_count)
  );

  // Tags left in flight once this cycle's grant and response settle
  assign outst_nxt = tag_count + OUT_CNT_W'(tag_push) - OUT_CNT_W'(tag_pop);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      discard_q <= '0;
    end else if (kill_i) begin
      // Still-held request will be granted later, drop its response too
      discard_q <= outst_nxt + OUT_CNT_W'(hold_d);
    end else if (bus_rvalid_i && discard_q != '0) begin
      discard_q <= discard_q - 1'b1;
    end
  end

  // Response of the old stream or in a kill cycle is dropped
  assign resp_valid_o = bus_rvalid_i & (discard_q == '0) & ~kill_i;

  assign resp_entry_o.addr  = tag_head.addr;
  assign resp_entry_o.instr = bus_rdata_i;
  assign resp_entry_o.priv  = tag_head.priv;

endmodule

/* verilog/ifetch_stage.sv */
`timescale 1ns/1ps
`include "ifetch_defs.svh"

module ifetch_stage (
  input  logic                      clk,
  input  logic                      rst_n,

  // Instruction bus
  output logic                      bus_req_o,
  output logic [`IFETCH_ADDR_W-1:0] bus_addr_o,
  input  logic                      bus_gnt_i,
  input  logic                      bus_rvalid_i,
  input  logic [`IFETCH_ADDR_W-1:0] bus_rdata_i,

  // Pipeline controller
  input  logic                      halt_if_i,
  input  logic                      kill_if_i,
  input  logic                      branch_i,
  input  logic [`IFETCH_ADDR_W-1:0] branch_addr_i,
  input  ifetch_pkg::privlvl_t      priv_lvl_i,
  input  logic [`IFETCH_ADDR_W-1:0] boot_addr_i,

  // Decode side
  output logic                      if_valid_o,
  input  logic                      id_ready_i,
  output logic [`IFETCH_ADDR_W-1:0] instr_o,
  output logic [`IFETCH_ADDR_W-1:0] instr_addr_o,
  output ifetch_pkg::privlvl_t      instr_priv_o,

  // Pipeline status
  output logic                      if_ready_o
);

  import ifetch_pkg::*;

  localparam int unsigned BUF_CNT_W = $clog2(`IFETCH_BUF_DEPTH + 1);
  localparam logic [BUF_CNT_W-1:0] BUF_DEPTH_C = BUF_CNT_W'(`IFETCH_BUF_DEPTH);

  logic                 resp_valid;
  fetch_entry_t         resp_entry;
  fetch_entry_t         buf_head;
  logic                 buf_empty;
  logic                 buf_pop;
  logic [BUF_CNT_W-1:0] buf_count;
  logic [BUF_CNT_W-1:0] buf_free;

  //////////////////////////////////////////////////////////////////////
  // Prefetcher
  //////////////////////////////////////////////////////////////////////

  // Free slots steer how far the prefetcher may run ahead
  assign buf_free = BUF_DEPTH_C - buf_count;

  ifetch_prefetcher u_prefetcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .boot_addr_i   (boot_addr_i),
    .halt_i        (halt_if_i),
    .kill_i        (kill_if_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .priv_lvl_i    (priv_lvl_i),
    .buf_free_i    (buf_free),
    .bus_req_o     (bus_req_o),
    .bus_addr_o    (bus_addr_o),
    .bus_gnt_i     (bus_gnt_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i),
    .resp_valid_o  (resp_valid),
    .resp_entry_o  (resp_entry)
  );

  //////////////////////////////////////////////////////////////////////
  // Instruction buffer
  //////////////////////////////////////////////////////////////////////

  // Transfer to decode pops the head
  assign buf_pop = if_valid_o & id_ready_i;

  // Kill empties the buffer on this edge
  ifetch_fifo #(
    .ENTRY_T (fetch_entry_t),
    .DEPTH   (`IFETCH_BUF_DEPTH)
  ) u_instr_buf (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (kill_if_i),
    .push_i      (resp_valid),
    .push_data_i (resp_entry),
    .pop_i       (buf_pop),
    .pop_data_o  (buf_head),
    .empty_o     (buf_empty),
    .full_o      (),
    .count_o     (buf_count)
  );

  //////////////////////////////////////////////////////////////////////
  // Decode handshake
  //////////////////////////////////////////////////////////////////////

  // Head is offered unless halted or killed
  assign if_valid_o = ~buf_empty & ~halt_if_i & ~kill_if_i;

  // Kill always lets the stage move, halt holds it
  assign if_ready_o = kill_if_i | (id_ready_i & ~halt_if_i);

  assign instr_o      = buf_head.instr;
  assign instr_addr_o = buf_head.addr;
  assign instr_priv_o = buf_head.priv;

endmodule

/* verification/ifetch_mem_model.sv */
`timescale 1ns/1ps
`include "ifetch_defs.svh"

module ifetch_mem_model #(
  parameter logic [`IFETCH_ADDR_W-1:0] SALT = '0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_i,
  input  logic [`IFETCH_ADDR_W-1:0] addr_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output logic [`IFETCH_ADDR_W-1:0] rdata_o
);

  // Granted addresses still owed a response, oldest first
  logic [`IFETCH_ADDR_W-1:0] pend_q [$];
  logic                      gnt_en_q;

  // Grant window opens on random cycles
  assign gnt_o = req_i & gnt_en_q;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_en_q <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      pend_q.delete();
    end else begin
      // Grant on about two cycles out of three
      gnt_en_q <= ($urandom_range(2, 0) != 0);
      // Pop before push so no response lands in its own grant cycle
      if (pend_q.size() != 0 && $urandom_range(1, 0) == 1) begin
        rvalid_o <= 1'b1;
        rdata_o  <= pend_q.pop_front() ^ SALT;
      end else begin
        rvalid_o <= 1'b0;
        rdata_o  <= $urandom();  // junk while idle
      end
      if (req_i && gnt_o) begin
        pend_q.push_back(addr_i);
      end
    end
  end

endmodule

/* verification/ifetch_tb.sv */
`timescale 1ns/1ps
`include "ifetch_defs.svh"

module ifetch_tb;

  import ifetch_pkg::*;

  localparam int unsigned   AW           = `IFETCH_ADDR_W;
  localparam logic [31:0]   SEED         = 32'h16fc_3043;
  localparam logic [AW-1:0] DATA_SALT    = 32'h5a3c_96e1;
  localparam logic [AW-1:0] BOOT_ADDR    = 32'h0000_0800;
  localparam int            RESET_CYCLES = 4;
  localparam int            RUN_CYCLES   = 2000;
  // Stimulus length plus half again as margin
  localparam int            TIMEOUT_CYCLES = RUN_CYCLES * 3 / 2;

  logic          clk;
  logic          rst_n;
  logic          halt_if;
  logic          kill_if;
  logic          branch;
  logic [AW-1:0] branch_addr;
  privlvl_t      priv_lvl;
  logic [AW-1:0] boot_addr;
  logic          id_ready;
  logic          bus_req;
  logic [AW-1:0] bus_addr;
  logic          bus_gnt;
  logic          bus_rvalid;
  logic [AW-1:0] bus_rdata;
  logic          if_valid;
  logic [AW-1:0] instr;
  logic [AW-1:0] instr_addr;
  privlvl_t      instr_priv;
  logic          if_ready;

  // Reference state for the checks
  logic [AW-1:0] exp_addr;
  logic          exp_known;
  privlvl_t      exp_priv;
  logic          held_pending;
  logic [AW-1:0] held_addr;
  int            errors    = 0;
  int            transfers = 0;
  int            kills     = 0;
  int            cycles    = 0;

  ifetch_stage dut0 (
    .clk (clk), .rst_n (rst_n),
    .bus_req_o (bus_req), .bus_addr_o (bus_addr), .bus_gnt_i (bus_gnt),
    .bus_rvalid_i (bus_rvalid), .bus_rdata_i (bus_rdata),
    .halt_if_i (halt_if), .kill_if_i (kill_if), .branch_i (branch),
    .branch_addr_i (branch_addr), .priv_lvl_i (priv_lvl), .boot_addr_i (boot_addr),
    .if_valid_o (if_valid), .id_ready_i (id_ready), .instr_o (instr),
    .instr_addr_o (instr_addr), .instr_priv_o (instr_priv), .if_ready_o (if_ready)
  );

  ifetch_mem_model #(.SALT (DATA_SALT)) mem0 (
    .clk (clk), .rst_n (rst_n), .req_i (bus_req), .addr_i (bus_addr),
    .gnt_o (bus_gnt), .rvalid_o (bus_rvalid), .rdata_o (bus_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic flag_mismatch(input string name, input logic [AW-1:0] got,
                               input logic [AW-1:0] expected);
    errors++;
    $display("FAILED %s: got %h expected %h", name, got, expected);
  endtask

  // One cycle of random controller and decode behavior
  task automatic drive_controls();
    logic do_kill;
    do_kill = ($urandom_range(99, 0) < 5);
    kill_if     <= do_kill;
    branch      <= do_kill && ($urandom_range(1, 0) == 1);
    halt_if     <= ($urandom_range(99, 0) < 12);
    id_ready    <= ($urandom_range(99, 0) < 75);
    branch_addr <= $urandom() & 32'h0000_fffc;
    // Level only moves together with a kill
    if (do_kill) begin
      case ($urandom_range(2, 0))
        0:       priv_lvl <= PRIV_LVL_U;
        1:       priv_lvl <= PRIV_LVL_S;
        default: priv_lvl <= PRIV_LVL_M;
      endcase
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks, sampled on the falling edge where all signals are settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!bus_req) else flag_mismatch("bus_req_o", AW'(bus_req), AW'(0));
      assert (!if_valid) else flag_mismatch("if_valid_o", AW'(if_valid), AW'(0));
      exp_addr     = BOOT_ADDR;
      exp_known    = 1'b1;
      exp_priv     = PRIV_LVL_M;
      held_pending = 1'b0;
    end else begin
      // Bus discipline
      assert (bus_addr[1:0] == 2'b00)
        else flag_mismatch("bus_addr_o[1:0]", AW'(bus_addr[1:0]), AW'(0));
      if (held_pending) begin
        assert (bus_req) else flag_mismatch("bus_req_o", AW'(bus_req), AW'(1));
        assert (bus_addr == held_addr) else flag_mismatch("bus_addr_o", bus_addr, held_addr);
      end
      held_pending = bus_req && !bus_gnt;
      held_addr    = bus_addr;
      // Halt and kill gating
      if (halt_if && !kill_if) begin
        assert (!if_ready) else flag_mismatch("if_ready_o", AW'(if_ready), AW'(0));
        assert (!if_valid) else flag_mismatch("if_valid_o", AW'(if_valid), AW'(0));
      end
      if (kill_if) begin
        assert (if_ready) else flag_mismatch("if_ready_o", AW'(if_ready), AW'(1));
        assert (!if_valid) else flag_mismatch("if_valid_o", AW'(if_valid), AW'(0));
      end
      // Free running stage follows decode readiness
      if (!halt_if && !kill_if) begin
        assert (if_ready == id_ready)
          else flag_mismatch("if_ready_o", AW'(if_ready), AW'(id_ready));
      end
      // Data, order and level of each transfer to decode
      if (if_valid && id_ready) begin
        transfers++;
        assert (instr == (instr_addr ^ DATA_SALT))
          else flag_mismatch("instr_o", instr, instr_addr ^ DATA_SALT);
        if (exp_known) begin
          assert (instr_addr == exp_addr) else flag_mismatch("instr_addr_o", instr_addr, exp_addr);
        end
        assert (instr_priv == exp_priv)
          else flag_mismatch("instr_priv_o", AW'(instr_priv), AW'(exp_priv));
        exp_addr  = instr_addr + AW'(4);
        exp_known = 1'b1;
      end
      // Kill without branch resumes at the prefetch PC, not checked
      if (kill_if) begin
        kills++;
        exp_known = branch;
        exp_addr  = branch_addr;
        exp_priv  = priv_lvl;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles without reaching the end of the run", TIMEOUT_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst_n       = 1'b0;
    halt_if     = 1'b0;
    kill_if     = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    priv_lvl    = PRIV_LVL_M;
    boot_addr   = BOOT_ADDR;
    id_ready    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (RUN_CYCLES) begin
      @(posedge clk);
      drive_controls();
    end
    // Let the last falling edge checks finish
    repeat (2) @(posedge clk);
    if (transfers == 0) begin
      errors++;
      $display("No instruction reached decode during the run");
    end
    $display("Summary: %0d cycles, %0d transfers, %0d kills, %0d errors",
             cycles, transfers, kills, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* ifetch.f */
+incdir+verilog
verilog/ifetch_pkg.sv
verilog/ifetch_fifo.sv
verilog/ifetch_prefetcher.sv
verilog/ifetch_stage.sv
verification/ifetch_mem_model.sv
verification/ifetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the ifetch testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ifetch_tb -f ifetch.f -o ifetch_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ifetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
